/* design/save_pkg.sv */
`default_nettype none

package save_pkg;

  // element width in bits, sums wrap at this width
  localparam int elem_w = 16;

  // tile geometry
  // 2 x 2 cells, each cell carries 4 lanes
  localparam int n_cells = 4;
  localparam int n_lanes = 4;

  // elements per tile, also per bank section
  localparam int n_elems = n_cells * n_lanes;

  // sections per bank
  localparam int n_section = 4;

  // deepest job, repeats per slot
  localparam int max_depth = 4;

  // accepted tile to sum in bank
  // one cycle in the packer, one in the bank adder
  localparam int pack_lat = 2;

  // block mode of a job
  // full uses every lane, half two lanes, quarter one lane
  typedef enum logic [1:0] {
    mode_full    = 2'd0,
    mode_half    = 2'd1,
    mode_quarter = 2'd2
  } block_mode_e;

  typedef logic signed [elem_w-1:0] elem_t;

  // raw tile from the array
  // index is cell * n_lanes + lane, cell is i * N_TILE + j
  typedef elem_t [n_elems-1:0] tile_t;

  // one accumulation section, filled slot by slot
  typedef elem_t [n_elems-1:0] section_t;

  // job command, sampled with start
  // depth runs 1 to max_depth
  typedef struct packed {
    block_mode_e mode;
    logic [2:0]  depth;
  } save_cmd_t;

  // fill position that follows a tile down the pipe
  typedef struct packed {
    logic [$clog2(n_section)-1:0] section;
    logic [1:0]                   slot;
    block_mode_e                  mode;
    logic                         valid;
  } fill_pos_t;

endpackage

`default_nettype wire

/* design/save_index_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module save_index_counter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  save_pkg::block_mode_e mode,
  input  logic [2:0]            depth,
  input  logic                  step,
  output logic [1:0]            section,
  output logic [1:0]            slot,
  output logic                  last
);
  import save_pkg::*;

  // final slot and final depth step of the running job
  logic [1:0]                   slot_max;
  logic [$clog2(max_depth)-1:0] dstep;
  logic [$clog2(max_depth)-1:0] dstep_max;
  logic [2:0]                   depth_m1;
  logic                         slot_wrap;
  logic                         dstep_wrap;

  assign depth_m1   = depth - 3'd1;
  assign slot_wrap  = (slot == slot_max);
  assign dstep_wrap = (dstep == dstep_max);

  // all three digits at their top value
  assign last = slot_wrap && dstep_wrap && (section == 2'(n_section - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      section   <= '0;
      slot      <= '0;
      dstep     <= '0;
      slot_max  <= '0;
      dstep_max <= '0;
    end else if (load) begin
      section <= '0;
      slot    <= '0;
      dstep   <= '0;
      // slots per section: 1, 2 or 4
      case (mode)
        mode_half:    slot_max <= 2'd1;
        mode_quarter: slot_max <= 2'd3;
        default:      slot_max <= 2'd0;
      endcase
      dstep_max <= depth_m1[$bits(dstep_max)-1:0];
    end else if (step) begin
      // slot fastest, then depth step, then section
      if (slot_wrap) begin
        slot <= '0;
        if (dstep_wrap) begin
          dstep   <= '0;
          section <= section + 2'd1;
        end else begin
          dstep <= dstep + 1'b1;
        end
      end else begin
        slot <= slot + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* design/save_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module save_controller (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  save_pkg::save_cmd_t cmd,
  input  logic                tile_valid,
  input  logic [1:0]          section,
  input  logic [1:0]          slot,
  input  logic                last,
  output logic                load,
  output logic                step,
  output save_pkg::fill_pos_t pos,
  output logic                swap,
  output logic                busy
);
  import save_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_flush
  } state_e;

  state_e                        state;
  block_mode_e                   mode_q;
  logic [$clog2(pack_lat+1)-1:0] flush_cnt;
  logic                          accept;

  // only the fill state takes tiles
  assign busy   = (state == st_fill);
  assign accept = tile_valid && busy;
  assign step   = accept;

  // start is dropped while filling
  assign load = start && !busy;

  // position of the tile accepted this cycle
  always_comb begin
    pos.section = section;
    pos.slot    = slot;
    pos.mode    = mode_q;
    pos.valid   = accept;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= st_idle;
      mode_q    <= mode_full;
      flush_cnt <= '0;
      swap      <= 1'b0;
    end else begin
      swap <= 1'b0;
      if (load) begin
        mode_q <= cmd.mode;
      end
      // wait for the last sum to land, then one swap pulse
      // runs on even if the next job has started
      if (flush_cnt != '0) begin
        flush_cnt <= flush_cnt - 1'b1;
        if (flush_cnt == 1) begin
          swap <= 1'b1;
        end
      end
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_fill;
          end
        end
        st_fill: begin
          if (accept && last) begin
            state     <= st_flush;
            flush_cnt <= $bits(flush_cnt)'(pack_lat);
          end
        end
        st_flush: begin
          // back to back job may start here
          if (start) begin
            state <= st_fill;
          end else if (flush_cnt == 1) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/tile_packer.sv */
`timescale 1ns/1ns
`default_nettype none

module tile_packer (
  input  logic                clk,
  input  logic                rst,
  input  save_pkg::tile_t     tile,
  input  save_pkg::fill_pos_t pos_in,
  output save_pkg::section_t  word,
  output save_pkg::fill_pos_t pos_out
);
  import save_pkg::*;

  // lanes kept per cell in half mode
  localparam int half_lanes = n_lanes / 2;

  section_t packed_word;

  // reshape by mode, unused positions stay zero
  always_comb begin
    packed_word = '0;
    case (pos_in.mode)
      mode_half: begin
        // lanes 0 and 1 of each cell, two slots per section
        for (int c = 0; c < n_cells; c++) begin
          for (int l = 0; l < half_lanes; l++) begin
            packed_word[(pos_in.slot[0] * n_cells + c) * half_lanes + l] =
              tile[c * n_lanes + l];
          end
        end
      end
      mode_quarter: begin
        // lane 0 only, four slots per section
        for (int c = 0; c < n_cells; c++) begin
          packed_word[pos_in.slot * n_cells + c] = tile[c * n_lanes];
        end
      end
      default: begin
        // full mode, straight copy
        packed_word = tile;
      end
    endcase
  end

  // position follows the word by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      pos_out <= '0;
    end else begin
      pos_out <= pos_in;
    end
  end

  // word only moves when a tile is taken
  always_ff @(posedge clk) begin
    if (pos_in.valid) begin
      word <= packed_word;
    end
  end

endmodule

`default_nettype wire

/* design/accum_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module accum_bank (
  input  logic                clk,
  input  logic                rst,
  input  save_pkg::section_t  word,
  input  save_pkg::fill_pos_t pos,
  input  logic                swap,
  output save_pkg::section_t  out_word,
  output logic                out_valid
);
  import save_pkg::*;

  // two banks, fill side and drain side
  section_t bank [2][n_section];

  logic                         fill_sel;
  logic                         add_sel;
  logic                         drain_active;
  logic [$clog2(n_section)-1:0] drain_ptr;

  // an add on the swap edge belongs to the next job
  // so it goes to the bank that becomes the fill side
  assign add_sel = fill_sel ^ swap;

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_sel     <= 1'b0;
      drain_active <= 1'b0;
      drain_ptr    <= '0;
      out_valid    <= 1'b0;
    end else begin
      out_valid <= drain_active;
      if (swap) begin
        fill_sel     <= ~fill_sel;
        drain_active <= 1'b1;
        drain_ptr    <= '0;
      end else if (drain_active) begin
        drain_ptr <= drain_ptr + 1'b1;
        // stop after the top section
        if (drain_ptr == $bits(drain_ptr)'(n_section - 1)) begin
          drain_active <= 1'b0;
        end
      end
    end
  end

  // section-wise add on fill side, clear on read on drain side
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < 2; b++) begin
        for (int s = 0; s < n_section; s++) begin
          bank[b][s] <= '0;
        end
      end
    end else begin
      if (pos.valid) begin
        // element-wise, wraps at elem_w
        for (int e = 0; e < n_elems; e++) begin
          bank[add_sel][pos.section][e] <= bank[add_sel][pos.section][e] + word[e];
        end
      end
      if (drain_active) begin
        bank[~fill_sel][drain_ptr] <= '0;
      end
    end
  end

  // drain register, one section per cycle
  always_ff @(posedge clk) begin
    if (drain_active) begin
      out_word <= bank[~fill_sel][drain_ptr];
    end
  end

endmodule

`default_nettype wire

/* design/save_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module save_unit_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  save_pkg::save_cmd_t cmd,
  input  logic                tile_valid,
  input  save_pkg::tile_t     tile,
  output save_pkg::section_t  out_word,
  output logic                out_valid,
  output logic                busy
);
  import save_pkg::*;

  logic       load;
  logic       step;
  logic       last;
  logic       swap;
  logic [1:0] section;
  logic [1:0] slot;

  // position at accept, then one cycle later beside the packed word
  fill_pos_t  fill_pos;
  fill_pos_t  pack_pos;
  section_t   pack_word;

  save_controller i_save_controller (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd        (cmd),
    .tile_valid (tile_valid),
    .section    (section),
    .slot       (slot),
    .last       (last),
    .load       (load),
    .step       (step),
    .pos        (fill_pos),
    .swap       (swap),
    .busy       (busy)
  );

  // counter samples the raw command on load
  save_index_counter i_save_index_counter (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .mode    (cmd.mode),
    .depth   (cmd.depth),
    .step    (step),
    .section (section),
    .slot    (slot),
    .last    (last)
  );

  tile_packer i_tile_packer (
    .clk     (clk),
    .rst     (rst),
    .tile    (tile),
    .pos_in  (fill_pos),
    .word    (pack_word),
    .pos_out (pack_pos)
  );

  accum_bank i_accum_bank (
    .clk       (clk),
    .rst       (rst),
    .word      (pack_word),
    .pos       (pack_pos),
    .swap      (swap),
    .out_word  (out_word),
    .out_valid (out_valid)
  );

endmodule

`default_nettype wire

/* sim/save_unit_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module save_unit_checker (
  input logic clk,
  input logic rst,
  input logic swap,
  input logic busy,
  input logic out_valid
);

  // failures seen, read by the testbench
  int assert_errors = 0;

  // swap is one cycle wide
  swap_pulse: assert property (@(posedge clk) disable iff (rst) swap |=> !swap)
    else begin
      $error("swap held longer than one cycle");
      assert_errors++;
    end

  // one cycle to start, then four words back to back
  drain_len: assert property (@(posedge clk) disable iff (rst)
      swap |=> !out_valid ##1 out_valid [*4] ##1 !out_valid)
    else begin
      $error("drain did not give exactly four words");
      assert_errors++;
    end

  // no new swap while the drain pointer runs
  no_overlap: assert property (@(posedge clk) disable iff (rst) swap |=> !swap [*4])
    else begin
      $error("swap during a running drain");
      assert_errors++;
    end

  // outputs quiet right out of reset
  reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !busy && !out_valid)
    else begin
      $error("busy or out_valid high after reset");
      assert_errors++;
    end

endmodule

`default_nettype wire

/* sim/save_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module save_unit_tb;
  import save_pkg::*;

  // one job per row
  // gap bit k%4 puts an idle cycle before tile k
  typedef struct packed {
    block_mode_e mode;
    logic [2:0]  depth;
    logic [3:0]  gap;
    logic        b2b;
  } row_t;

  localparam int n_rows = 6;
  localparam row_t rows [n_rows] = '{
    '{mode_full,    3'd1, 4'b0000, 1'b0},
    '{mode_half,    3'd2, 4'b0101, 1'b0},
    '{mode_quarter, 3'd1, 4'b0010, 1'b1},
    '{mode_full,    3'd3, 4'b0000, 1'b1},
    '{mode_quarter, 3'd4, 4'b1001, 1'b0},
    '{mode_half,    3'd4, 4'b0000, 1'b0}
  };

  logic      clk = 1'b0;
  logic      rst;
  logic      start;
  save_cmd_t cmd;
  logic      tile_valid;
  tile_t     tile;
  section_t  out_word;
  logic      out_valid;
  logic      busy;

  // expected drain words in output order
  section_t exp_q [$];
  int       value_errors = 0;
  int       proto_errors = 0;
  int       total_errors;

  always #2 clk = ~clk;

  save_unit_top i_save_unit_top (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cmd        (cmd),
    .tile_valid (tile_valid),
    .tile       (tile),
    .out_word   (out_word),
    .out_valid  (out_valid),
    .busy       (busy)
  );

  bind save_unit_top save_unit_checker i_save_unit_checker (
    .clk       (clk),
    .rst       (rst),
    .swap      (swap),
    .busy      (busy),
    .out_valid (out_valid)
  );

  function automatic int slots_of(block_mode_e m);
    case (m)
      mode_half:    return 2;
      mode_quarter: return 4;
      default:      return 1;
    endcase
  endfunction

  function automatic int tiles_of(row_t r);
    return n_section * slots_of(r.mode) * r.depth;
  endfunction

  function automatic tile_t random_tile();
    tile_t t;
    for (int e = 0; e < n_elems; e++) begin
      t[e] = elem_t'($urandom);
    end
    return t;
  endfunction

  // model of the block mode layout
  function automatic section_t pack_tile(tile_t t, block_mode_e m, int slot);
    section_t w;
    w = '0;
    for (int c = 0; c < n_cells; c++) begin
      for (int l = 0; l < n_lanes; l++) begin
        if (m == mode_full) begin
          w[c * 4 + l] = t[c * 4 + l];
        end else if (m == mode_half && l < 2) begin
          w[(slot * 4 + c) * 2 + l] = t[c * 4 + l];
        end else if (m == mode_quarter && l == 0) begin
          w[slot * 4 + c] = t[c * 4];
        end
      end
    end
    return w;
  endfunction

  // element-wise sum that wraps at 16 bits
  function automatic section_t add_sections(section_t a, section_t b);
    section_t s;
    for (int e = 0; e < n_elems; e++) begin
      s[e] = a[e] + b[e];
    end
    return s;
  endfunction

  task automatic compare_section(input string name, input section_t exp, input section_t act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      value_errors++;
    end
  endtask

  // junk tiles while idle must not move anything
  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      start      <= 1'b0;
      tile_valid <= 1'b1;
      tile       <= random_tile();
      @(negedge clk);
      compare_flag("busy", 1'b0, busy);
      compare_flag("out_valid", 1'b0, out_valid);
    end
  endtask

  // returns on the edge that samples the last tile
  task automatic run_job(input row_t r, input bit chained);
    section_t mbank [n_section];
    tile_t    t;
    int       slots;
    int       sec;
    slots = slots_of(r.mode);
    for (int s = 0; s < n_section; s++) begin
      mbank[s] = '0;
    end
    // a chained job drives start on the edge that takes the previous last tile
    if (!chained) begin
      @(posedge clk);
    end
    start      <= 1'b1;
    cmd        <= '{mode: r.mode, depth: r.depth};
    tile_valid <= 1'b0;
    @(negedge clk);
    compare_flag("busy", 1'b0, busy);
    for (int k = 0; k < tiles_of(r); k++) begin
      if (r.gap[k % 4]) begin
        @(posedge clk);
        start      <= 1'b0;
        tile_valid <= 1'b0;
        tile       <= random_tile();
      end
      t = random_tile();
      @(posedge clk);
      // stray start with another command mid job
      start      <= (k == 2);
      cmd        <= '{mode: mode_quarter, depth: 3'd1};
      tile_valid <= 1'b1;
      tile       <= t;
      // slot runs fastest then depth step then section
      sec = k / (slots * r.depth);
      mbank[sec] = add_sections(mbank[sec], pack_tile(t, r.mode, k % slots));
      if (k == 0) begin
        @(negedge clk);
        compare_flag("busy", 1'b1, busy);
      end
    end
    for (int s = 0; s < n_section; s++) begin
      exp_q.push_back(mbank[s]);
    end
    @(posedge clk);
  endtask

  // strobes drop on the last tile edge and busy is already low
  task automatic end_job();
    start      <= 1'b0;
    tile_valid <= 1'b0;
    @(negedge clk);
    compare_flag("busy", 1'b0, busy);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 30) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("drain stalled, %0d expected words never came out", exp_q.size());
      proto_errors++;
      exp_q.delete();
    end
  endtask

  // drain monitor sampled mid cycle
  always @(negedge clk) begin
    if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("out_valid high with no word expected");
        proto_errors++;
      end else begin
        compare_section("out_word", exp_q.pop_front(), out_word);
      end
    end
  end

  initial begin
    bit chained;
    void'($urandom(75));
    rst        <= 1'b1;
    start      <= 1'b0;
    cmd        <= '{mode: mode_full, depth: 3'd1};
    tile_valid <= 1'b0;
    tile       <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // quiet after reset with junk tiles ignored
    idle_cycles(4);
    chained = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      run_job(rows[r], chained);
      chained = rows[r].b2b;
      if (!chained) begin
        end_job();
        wait_drain();
        idle_cycles(3);
      end
    end
    wait_drain();
    // any extra word shows up here
    repeat (10) @(negedge clk);
    total_errors = value_errors + proto_errors + i_save_unit_top.i_save_unit_checker.assert_errors;
    $display("errors: value %0d, protocol %0d, assertion %0d", value_errors, proto_errors,
             i_save_unit_top.i_save_unit_checker.assert_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // run limit from tile count and per job overhead
  initial begin
    int cyc;
    cyc = 8 + 30;
    for (int r = 0; r < n_rows; r++) begin
      cyc += 2 * tiles_of(rows[r]) + 20;
    end
    #(cyc * 4 + 400);
    $display("watchdog expired, simulation did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
design/save_pkg.sv
design/save_index_counter.sv
design/save_controller.sv
design/tile_packer.sv
design/accum_bank.sv
design/save_unit_top.sv
sim/save_unit_checker.sv
sim/save_unit_tb.sv
